// ==== Bender.yml ====
package:
  name: forward_unit

sources:
  # Synthesizable design, package first
  - rtl/fwd_pkg.sv
  - rtl/reg_file.sv
  - rtl/operand_latch.sv
  - rtl/hazard_compare.sv
  - rtl/bypass_mux_bank.sv
  - rtl/forward_top.sv

  # Verification environment
  - target: test
    files:
      - verif/forward_checker.sv
      - verif/tb_forward_top.sv

// ==== forward_unit.f ====
rtl/fwd_pkg.sv
rtl/reg_file.sv
rtl/operand_latch.sv
rtl/hazard_compare.sv
rtl/bypass_mux_bank.sv
rtl/forward_top.sv
verif/forward_checker.sv
verif/tb_forward_top.sv

// ==== rtl/bypass_mux_bank.sv ====
// Operand bypass multiplexers
module bypass_mux_bank (
    input  logic              clk,
    input  logic              reset_i,
    input  fwd_pkg::fwd_sel_t sel_i [fwd_pkg::NUM_OPERANDS],
    input  fwd_pkg::word_t    cmp_rs_base_i,
    input  fwd_pkg::word_t    cmp_rt_base_i,
    input  fwd_pkg::word_t    alu_rs_base_i,
    input  fwd_pkg::word_t    alu_rt_base_i,
    input  fwd_pkg::word_t    alu_result_i,
    input  fwd_pkg::word_t    mem_data_i,
    output fwd_pkg::word_t    cmp_rs_data_o,
    output fwd_pkg::word_t    cmp_rt_data_o,
    output fwd_pkg::word_t    alu_rs_data_o,
    output fwd_pkg::word_t    alu_rt_data_o
);

    import fwd_pkg::*;

    word_t base [NUM_OPERANDS];   // Value used when nothing newer is in flight
    word_t data [NUM_OPERANDS];

    // Compare operands take the register file read, ALU operands the latch
    assign base[OP_CMP_RS] = cmp_rs_base_i;
    assign base[OP_CMP_RT] = cmp_rt_base_i;
    assign base[OP_ALU_RS] = alu_rs_base_i;
    assign base[OP_ALU_RT] = alu_rt_base_i;

    for (genvar k = 0; k < NUM_OPERANDS; k++) begin : g_mux
        always_comb begin
            case (sel_i[k])
                FWD_ALU: data[k] = alu_result_i;
                FWD_MEM: data[k] = mem_data_i;
                default: data[k] = base[k];   // FWD_NONE
            endcase
        end

        // The selects come from the comparators and must never carry the
        // spare encoding, which the case above would quietly treat as no forward
        a_sel_defined: assert property (
            @(posedge clk) disable iff (reset_i)
            sel_i[k] inside {FWD_NONE, FWD_ALU, FWD_MEM}
        ) else $error("bypass_mux_bank: operand %0d has undefined select %b", k, sel_i[k]);
    end

    assign cmp_rs_data_o = data[OP_CMP_RS];
    assign cmp_rt_data_o = data[OP_CMP_RT];
    assign alu_rs_data_o = data[OP_ALU_RS];
    assign alu_rt_data_o = data[OP_ALU_RT];   // Also serves as store data

endmodule : bypass_mux_bank

// ==== rtl/forward_top.sv ====
// Operand forwarding subsystem
module forward_top (
    input  logic              clk,
    input  logic              reset_i,

    // Decode stage
    input  fwd_pkg::reg_num_t rs_i,
    input  fwd_pkg::reg_num_t rt_i,
    input  logic              advance_i,

    // ALU stage destination
    input  logic              alu_we_i,
    input  fwd_pkg::reg_num_t alu_rn_i,
    input  fwd_pkg::word_t    alu_result_i,

    // Memory stage destination
    input  logic              mem_we_i,
    input  fwd_pkg::reg_num_t mem_rn_i,
    input  fwd_pkg::word_t    mem_data_i,

    // Write-back
    input  logic              wb_we_i,
    input  fwd_pkg::reg_num_t wb_rn_i,
    input  fwd_pkg::word_t    wb_data_i,

    // Forwarded operands
    output fwd_pkg::word_t    cmp_rs_data_o,
    output fwd_pkg::word_t    cmp_rt_data_o,
    output fwd_pkg::word_t    alu_rs_data_o,
    output fwd_pkg::word_t    alu_rt_data_o,

    // Chosen sources
    output fwd_pkg::fwd_sel_t cmp_rs_sel_o,
    output fwd_pkg::fwd_sel_t cmp_rt_sel_o,
    output fwd_pkg::fwd_sel_t alu_rs_sel_o,
    output fwd_pkg::fwd_sel_t alu_rt_sel_o
);

    import fwd_pkg::*;

    word_t    rs_rdata;
    word_t    rt_rdata;
    reg_num_t ex_rs_num;
    reg_num_t ex_rt_num;
    word_t    ex_rs_data;
    word_t    ex_rt_data;
    reg_num_t op_num [NUM_OPERANDS];
    fwd_sel_t op_sel [NUM_OPERANDS];

    reg_file u_reg_file (
        .clk         (clk),
        .reset_i     (reset_i),
        .we_i        (wb_we_i),
        .wr_num_i    (wb_rn_i),
        .wr_data_i   (wb_data_i),
        .rd_a_num_i  (rs_i),
        .rd_b_num_i  (rt_i),
        .rd_a_data_o (rs_rdata),
        .rd_b_data_o (rt_rdata)
    );

    operand_latch u_operand_latch (
        .clk          (clk),
        .reset_i      (reset_i),
        .advance_i    (advance_i),
        .rs_num_i     (rs_i),
        .rt_num_i     (rt_i),
        .rs_data_i    (rs_rdata),
        .rt_data_i    (rt_rdata),
        .ex_rs_num_o  (ex_rs_num),
        .ex_rt_num_o  (ex_rt_num),
        .ex_rs_data_o (ex_rs_data),
        .ex_rt_data_o (ex_rt_data)
    );

    // Decode numbers first, then the latched ones
    assign op_num[OP_CMP_RS] = rs_i;
    assign op_num[OP_CMP_RT] = rt_i;
    assign op_num[OP_ALU_RS] = ex_rs_num;
    assign op_num[OP_ALU_RT] = ex_rt_num;

    for (genvar k = 0; k < NUM_OPERANDS; k++) begin : g_cmp
        hazard_compare u_hazard_compare (
            .alu_we_i (alu_we_i),
            .alu_rn_i (alu_rn_i),
            .mem_we_i (mem_we_i),
            .mem_rn_i (mem_rn_i),
            .op_num_i (op_num[k]),
            .sel_o    (op_sel[k])
        );
    end

    bypass_mux_bank u_bypass_mux_bank (
        .clk           (clk),
        .reset_i       (reset_i),
        .sel_i         (op_sel),
        .cmp_rs_base_i (rs_rdata),
        .cmp_rt_base_i (rt_rdata),
        .alu_rs_base_i (ex_rs_data),
        .alu_rt_base_i (ex_rt_data),
        .alu_result_i  (alu_result_i),
        .mem_data_i    (mem_data_i),
        .cmp_rs_data_o (cmp_rs_data_o),
        .cmp_rt_data_o (cmp_rt_data_o),
        .alu_rs_data_o (alu_rs_data_o),
        .alu_rt_data_o (alu_rt_data_o)
    );

    assign cmp_rs_sel_o = op_sel[OP_CMP_RS];
    assign cmp_rt_sel_o = op_sel[OP_CMP_RT];
    assign alu_rs_sel_o = op_sel[OP_ALU_RS];
    assign alu_rt_sel_o = op_sel[OP_ALU_RT];

endmodule : forward_top

// ==== rtl/fwd_pkg.sv ====
// Operand forwarding shared types
package fwd_pkg;

    // Widths fixed by the instruction set
    localparam int REG_NUM_W = 5;
    localparam int WORD_W    = 32;
    localparam int NUM_REGS  = 1 << REG_NUM_W;   // One word per register number

    // A register number as found in the rs, rt and destination fields
    typedef logic [REG_NUM_W-1:0] reg_num_t;

    // A 32-bit data word as carried by the datapath
    typedef logic [WORD_W-1:0] word_t;

    // Source of a forwarded operand
    // FWD_NONE takes the register file read data or the latched data
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_ALU  = 2'd1,   // Result leaving the ALU stage
        FWD_MEM  = 2'd2    // Data leaving the memory stage
    } fwd_sel_t;

    // Number of operands that go through the bypass
    localparam int NUM_OPERANDS = 4;

    // Operand positions in the comparator loop and in the mux bank
    // The compare pair feeds the branch comparator in decode
    localparam int OP_CMP_RS = 0;
    localparam int OP_CMP_RT = 1;

    // The ALU pair feeds the ALU inputs, rt is also the store data
    localparam int OP_ALU_RS = 2;
    localparam int OP_ALU_RT = 3;

endpackage : fwd_pkg

// ==== rtl/hazard_compare.sv ====
// Forwarding source comparator
module hazard_compare (
    input  logic              alu_we_i,
    input  fwd_pkg::reg_num_t alu_rn_i,
    input  logic              mem_we_i,
    input  fwd_pkg::reg_num_t mem_rn_i,
    input  fwd_pkg::reg_num_t op_num_i,
    output fwd_pkg::fwd_sel_t sel_o
);

    import fwd_pkg::*;

    logic alu_hit;
    logic mem_hit;

    // A destination of zero is a discarded result and never matches
    assign alu_hit = alu_we_i && (alu_rn_i == op_num_i) && (alu_rn_i != '0);
    assign mem_hit = mem_we_i && (mem_rn_i == op_num_i) && (mem_rn_i != '0);

    always_comb begin
        fwd_sel_t sel;

        // The ALU stage holds the younger result, so it wins over memory
        if (alu_hit) begin
            sel = FWD_ALU;
        end else if (mem_hit) begin
            sel = FWD_MEM;
        end else begin
            sel = FWD_NONE;
        end
        sel_o = sel;

        // Register zero must always come from the read port
        if (op_num_i == '0) begin
            a_no_zero_fwd: assert (sel == FWD_NONE)
                else $error("hazard_compare: register zero forwarded from %s", sel.name());
        end
    end

endmodule : hazard_compare

// ==== rtl/operand_latch.sv ====
// Decode to ALU operand latch
module operand_latch (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              advance_i,
    input  fwd_pkg::reg_num_t rs_num_i,
    input  fwd_pkg::reg_num_t rt_num_i,
    input  fwd_pkg::word_t    rs_data_i,
    input  fwd_pkg::word_t    rt_data_i,
    output fwd_pkg::reg_num_t ex_rs_num_o,
    output fwd_pkg::reg_num_t ex_rt_num_o,
    output fwd_pkg::word_t    ex_rs_data_o,
    output fwd_pkg::word_t    ex_rt_data_o
);

    import fwd_pkg::*;

    reg_num_t rs_num_q;
    reg_num_t rt_num_q;
    word_t    rs_data_q;
    word_t    rt_data_q;

    // Register numbers of the instruction now in the ALU stage
    // Cleared numbers read as register zero, which never forwards
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rs_num_q <= '0;
            rt_num_q <= '0;
        end else if (advance_i) begin
            rs_num_q <= rs_num_i;
            rt_num_q <= rt_num_i;
        end
    end

    // Read data captured with the same advance as the numbers
    // The register file has already applied write-through to it
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rs_data_q <= '0;
            rt_data_q <= '0;
        end else if (advance_i) begin
            rs_data_q <= rs_data_i;
            rt_data_q <= rt_data_i;
        end
    end

    assign ex_rs_num_o  = rs_num_q;
    assign ex_rt_num_o  = rt_num_q;
    assign ex_rs_data_o = rs_data_q;
    assign ex_rt_data_o = rt_data_q;

endmodule : operand_latch

// ==== rtl/reg_file.sv ====
// Integer register file
module reg_file (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             we_i,
    input  fwd_pkg::reg_num_t wr_num_i,
    input  fwd_pkg::word_t    wr_data_i,
    input  fwd_pkg::reg_num_t rd_a_num_i,
    input  fwd_pkg::reg_num_t rd_b_num_i,
    output fwd_pkg::word_t    rd_a_data_o,
    output fwd_pkg::word_t    rd_b_data_o
);

    import fwd_pkg::*;

    word_t regs [NUM_REGS];   // Entry zero is never written

    logic wr_valid;

    // Register zero is hardwired, so a write to it is dropped
    assign wr_valid = we_i && (wr_num_i != '0);

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            regs[wr_num_i] <= wr_data_i;
        end
    end

    // One read port, with the write-back value bypassed when the numbers match
    function automatic word_t read_port(
        input reg_num_t num,
        input logic     wr_en,
        input reg_num_t wr_num,
        input word_t    wr_data,
        input word_t    stored
    );
        word_t value;
        if (num == '0) begin
            value = '0;               // Never depends on the contents of entry zero
        end else if (wr_en && (wr_num == num)) begin
            value = wr_data;          // Same-cycle write-through
        end else begin
            value = stored;
        end
        return value;
    endfunction

    assign rd_a_data_o = read_port(rd_a_num_i, wr_valid, wr_num_i, wr_data_i,
                                   regs[rd_a_num_i]);
    assign rd_b_data_o = read_port(rd_b_num_i, wr_valid, wr_num_i, wr_data_i,
                                   regs[rd_b_num_i]);

    // The array itself has no reset, so zero on register zero must hold on every cycle
    a_rd_a_zero: assert property (
        @(posedge clk) disable iff (reset_i)
        (rd_a_num_i == '0) |-> (rd_a_data_o == '0)
    ) else $error("reg_file: port A read of register zero returned %h", rd_a_data_o);

    a_rd_b_zero: assert property (
        @(posedge clk) disable iff (reset_i)
        (rd_b_num_i == '0) |-> (rd_b_data_o == '0)
    ) else $error("reg_file: port B read of register zero returned %h", rd_b_data_o);

endmodule : reg_file

// ==== verif/forward_checker.sv ====
// Forwarding output checker
module forward_checker (
    input  logic              clk,
    input  logic              check_en_i,
    input  fwd_pkg::word_t    cmp_rs_data_i,
    input  fwd_pkg::word_t    cmp_rt_data_i,
    input  fwd_pkg::word_t    alu_rs_data_i,
    input  fwd_pkg::word_t    alu_rt_data_i,
    input  fwd_pkg::fwd_sel_t cmp_rs_sel_i,
    input  fwd_pkg::fwd_sel_t cmp_rt_sel_i,
    input  fwd_pkg::fwd_sel_t alu_rs_sel_i,
    input  fwd_pkg::fwd_sel_t alu_rt_sel_i,
    input  fwd_pkg::word_t    exp_cmp_rs_data_i,
    input  fwd_pkg::word_t    exp_cmp_rt_data_i,
    input  fwd_pkg::word_t    exp_alu_rs_data_i,
    input  fwd_pkg::word_t    exp_alu_rt_data_i,
    input  fwd_pkg::fwd_sel_t exp_cmp_rs_sel_i,
    input  fwd_pkg::fwd_sel_t exp_cmp_rt_sel_i,
    input  fwd_pkg::fwd_sel_t exp_alu_rs_sel_i,
    input  fwd_pkg::fwd_sel_t exp_alu_rt_sel_i,
    output int                cycle_count_o,
    output int                error_count_o
);

    timeunit 1ns;
    timeprecision 1ps;

    import fwd_pkg::*;

    int cycles = 0;        // Sampled cycles over the whole run
    int errors = 0;
    int test_cycles = 0;   // Counts for the test now running
    int test_errors = 0;
    int test_count = 0;

    assign cycle_count_o = cycles;
    assign error_count_o = errors;

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_sel(input string name, input logic [1:0] expected,
                             input logic [1:0] actual);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s expected %b, actual %b", $time, name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    // Mid-cycle sample, well after the inputs settle and before the next edge
    always @(negedge clk) begin
        if (check_en_i) begin
            check_sel("cmp_rs_sel_o", exp_cmp_rs_sel_i, cmp_rs_sel_i);
            check_sel("cmp_rt_sel_o", exp_cmp_rt_sel_i, cmp_rt_sel_i);
            check_sel("alu_rs_sel_o", exp_alu_rs_sel_i, alu_rs_sel_i);
            check_sel("alu_rt_sel_o", exp_alu_rt_sel_i, alu_rt_sel_i);
            check_word("cmp_rs_data_o", exp_cmp_rs_data_i, cmp_rs_data_i);
            check_word("cmp_rt_data_o", exp_cmp_rt_data_i, cmp_rt_data_i);
            check_word("alu_rs_data_o", exp_alu_rs_data_i, alu_rs_data_i);
            check_word("alu_rt_data_o", exp_alu_rt_data_i, alu_rt_data_i);
            cycles++;
            test_cycles++;
        end
    end

    task automatic end_test(input string name);
        $display("Test %-14s %4d cycles checked, %0d mismatches", name, test_cycles, test_errors);
        test_count++;
        test_cycles = 0;   // Next test starts from a clean count
        test_errors = 0;
    endtask

    task automatic print_totals();
        $display("Totals: %0d tests, %0d cycles checked, %0d mismatches",
                 test_count, cycles, errors);
    endtask

endmodule : forward_checker

// ==== verif/tb_forward_top.sv ====
// Forwarding subsystem testbench
module tb_forward_top;

    timeunit 1ns;
    timeprecision 1ps;

    import fwd_pkg::*;

    localparam logic [31:0] LCG_SEED      = 32'he037_3c50;
    localparam int          RANDOM_CYCLES = 500;
    localparam int          CHECK_TIMEOUT = 4;   // Cycles to wait for one checker sample
    localparam int          DRIVE_DELAY   = 2;

    logic     clk;
    logic     reset_i;
    reg_num_t rs_i;
    reg_num_t rt_i;
    logic     advance_i;
    logic     alu_we_i;
    reg_num_t alu_rn_i;
    word_t    alu_result_i;
    logic     mem_we_i;
    reg_num_t mem_rn_i;
    word_t    mem_data_i;
    logic     wb_we_i;
    reg_num_t wb_rn_i;
    word_t    wb_data_i;
    word_t    cmp_rs_data;
    word_t    cmp_rt_data;
    word_t    alu_rs_data;
    word_t    alu_rt_data;
    fwd_sel_t cmp_rs_sel;
    fwd_sel_t cmp_rt_sel;
    fwd_sel_t alu_rs_sel;
    fwd_sel_t alu_rt_sel;

    logic        check_en;
    int          cycles_checked;
    int          error_count;
    word_t       exp_data [NUM_OPERANDS];
    fwd_sel_t    exp_sel [NUM_OPERANDS];
    logic [31:0] lcg_state;

    // Shadow copy of the register file and of the ALU stage latch
    word_t    shadow_regs [NUM_REGS];
    reg_num_t shadow_ex_rs_num;
    reg_num_t shadow_ex_rt_num;
    word_t    shadow_ex_rs_data;
    word_t    shadow_ex_rt_data;

    forward_top forward_top_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .rs_i          (rs_i),
        .rt_i          (rt_i),
        .advance_i     (advance_i),
        .alu_we_i      (alu_we_i),
        .alu_rn_i      (alu_rn_i),
        .alu_result_i  (alu_result_i),
        .mem_we_i      (mem_we_i),
        .mem_rn_i      (mem_rn_i),
        .mem_data_i    (mem_data_i),
        .wb_we_i       (wb_we_i),
        .wb_rn_i       (wb_rn_i),
        .wb_data_i     (wb_data_i),
        .cmp_rs_data_o (cmp_rs_data),
        .cmp_rt_data_o (cmp_rt_data),
        .alu_rs_data_o (alu_rs_data),
        .alu_rt_data_o (alu_rt_data),
        .cmp_rs_sel_o  (cmp_rs_sel),
        .cmp_rt_sel_o  (cmp_rt_sel),
        .alu_rs_sel_o  (alu_rs_sel),
        .alu_rt_sel_o  (alu_rt_sel)
    );

    forward_checker u_checker (
        .clk               (clk),
        .check_en_i        (check_en),
        .cmp_rs_data_i     (cmp_rs_data),
        .cmp_rt_data_i     (cmp_rt_data),
        .alu_rs_data_i     (alu_rs_data),
        .alu_rt_data_i     (alu_rt_data),
        .cmp_rs_sel_i      (cmp_rs_sel),
        .cmp_rt_sel_i      (cmp_rt_sel),
        .alu_rs_sel_i      (alu_rs_sel),
        .alu_rt_sel_i      (alu_rt_sel),
        .exp_cmp_rs_data_i (exp_data[OP_CMP_RS]),
        .exp_cmp_rt_data_i (exp_data[OP_CMP_RT]),
        .exp_alu_rs_data_i (exp_data[OP_ALU_RS]),
        .exp_alu_rt_data_i (exp_data[OP_ALU_RT]),
        .exp_cmp_rs_sel_i  (exp_sel[OP_CMP_RS]),
        .exp_cmp_rt_sel_i  (exp_sel[OP_CMP_RT]),
        .exp_alu_rs_sel_i  (exp_sel[OP_ALU_RS]),
        .exp_alu_rt_sel_i  (exp_sel[OP_ALU_RT]),
        .cycle_count_o     (cycles_checked),
        .error_count_o     (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t rand_word();
        lcg_state = lcg_next(lcg_state);
        return lcg_state;
    endfunction

    // Numbers 0 to 7 only, so that stage destinations hit often
    function automatic reg_num_t rand_num();
        word_t w;
        w = rand_word();
        return reg_num_t'(w[18:16]);
    endfunction

    function automatic logic rand_bit();
        word_t w;
        w = rand_word();
        return w[30];
    endfunction

    // Register read as the decode stage sees it, write-back included
    function automatic word_t read_ref(input reg_num_t num);
        word_t value;
        if (num == '0) begin
            value = '0;
        end else if (wb_we_i && wb_rn_i == num) begin
            value = wb_data_i;
        end else begin
            value = shadow_regs[num];
        end
        return value;
    endfunction

    // Expected select and data for one operand, packed as {select, data}
    function automatic logic [33:0] ref_operand(
        input reg_num_t num,
        input word_t    base,
        input logic     alu_we,
        input reg_num_t alu_rn,
        input word_t    alu_result,
        input logic     mem_we,
        input reg_num_t mem_rn,
        input word_t    mem_data
    );
        fwd_sel_t sel;
        word_t    data;
        sel  = FWD_NONE;
        data = base;
        if (num != '0 && alu_we && alu_rn == num) begin
            sel  = FWD_ALU;        // Younger result wins
            data = alu_result;
        end else if (num != '0 && mem_we && mem_rn == num) begin
            sel  = FWD_MEM;
            data = mem_data;
        end
        return {sel, data};
    endfunction

    task automatic compute_expected();
        reg_num_t    num [NUM_OPERANDS];
        word_t       base [NUM_OPERANDS];
        logic [33:0] r;
        num[OP_CMP_RS]  = rs_i;
        num[OP_CMP_RT]  = rt_i;
        num[OP_ALU_RS]  = shadow_ex_rs_num;
        num[OP_ALU_RT]  = shadow_ex_rt_num;
        base[OP_CMP_RS] = read_ref(rs_i);
        base[OP_CMP_RT] = read_ref(rt_i);
        base[OP_ALU_RS] = shadow_ex_rs_data;
        base[OP_ALU_RT] = shadow_ex_rt_data;
        for (int k = 0; k < NUM_OPERANDS; k++) begin
            r = ref_operand(num[k], base[k], alu_we_i, alu_rn_i, alu_result_i,
                            mem_we_i, mem_rn_i, mem_data_i);
            exp_sel[k]  = fwd_sel_t'(r[33:32]);
            exp_data[k] = r[31:0];
        end
    endtask

    // Applies the rising edge to the shadow state, with the inputs held at that edge
    task automatic commit_shadow();
        word_t rs_val;
        word_t rt_val;
        rs_val = read_ref(rs_i);   // Reads see the write-through before the array changes
        rt_val = read_ref(rt_i);
        if (wb_we_i && wb_rn_i != '0) begin
            shadow_regs[wb_rn_i] = wb_data_i;
        end
        if (reset_i) begin
            shadow_ex_rs_num  = '0;
            shadow_ex_rt_num  = '0;
            shadow_ex_rs_data = '0;
            shadow_ex_rt_data = '0;
        end else if (advance_i) begin
            shadow_ex_rs_num  = rs_i;
            shadow_ex_rt_num  = rt_i;
            shadow_ex_rs_data = rs_val;
            shadow_ex_rt_data = rt_val;
        end
    endtask

    task automatic step();
        @(posedge clk);
        commit_shadow();
        #DRIVE_DELAY;
    endtask

    task automatic settle_and_check();
        int prev;
        int waited;
        compute_expected();
        prev   = cycles_checked;
        waited = 0;
        while (cycles_checked == prev && waited < CHECK_TIMEOUT) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (cycles_checked == prev) begin
            $display("Timeout: the checker took no sample within %0d cycles", CHECK_TIMEOUT);
            $display("Simulation failed");
            $finish;
        end
    endtask

    task automatic clear_inputs();
        rs_i         = '0;
        rt_i         = '0;
        advance_i    = 1'b0;
        alu_we_i     = 1'b0;
        alu_rn_i     = '0;
        alu_result_i = '0;
        mem_we_i     = 1'b0;
        mem_rn_i     = '0;
        mem_data_i   = '0;
        wb_we_i      = 1'b0;
        wb_rn_i      = '0;
        wb_data_i    = '0;
    endtask

    task automatic check_reset_state();
        for (int i = 0; i < 3; i++) begin
            step();
            alu_we_i     = 1'b1;   // Live destinations must not reach the cleared ALU operands
            alu_rn_i     = reg_num_t'(i + 1);
            alu_result_i = rand_word();
            mem_we_i     = 1'b1;
            mem_rn_i     = reg_num_t'(i + 4);
            mem_data_i   = rand_word();
            settle_and_check();
        end
        step();
        clear_inputs();
        settle_and_check();
        u_checker.end_test("reset_state");
    endtask

    task automatic check_reg_file();
        for (int r = 1; r < 8; r++) begin
            step();
            wb_we_i   = 1'b1;
            wb_rn_i   = reg_num_t'(r);
            wb_data_i = rand_word();
            rs_i      = reg_num_t'(r);       // Same-cycle write-through
            rt_i      = reg_num_t'(r - 1);   // Written one edge earlier
            settle_and_check();
        end
        step();
        wb_rn_i   = '0;                   // Dropped write to register zero
        wb_data_i = 32'hdead_beef;
        rs_i      = '0;
        settle_and_check();
        for (int r = 0; r < 8; r++) begin
            step();
            wb_we_i = 1'b0;
            rs_i    = reg_num_t'(r);
            rt_i    = reg_num_t'(7 - r);
            settle_and_check();
        end
        u_checker.end_test("reg_file");
    endtask

    task automatic check_priority();
        step();
        clear_inputs();
        advance_i = 1'b1;
        rs_i      = 5'd3;
        rt_i      = 5'd5;
        settle_and_check();
        step();
        advance_i    = 1'b0;
        alu_we_i     = 1'b1;   // Both stages on register 3
        alu_rn_i     = 5'd3;
        alu_result_i = rand_word();
        mem_we_i     = 1'b1;
        mem_rn_i     = 5'd3;
        mem_data_i   = rand_word();
        settle_and_check();
        step();
        alu_we_i = 1'b0;
        settle_and_check();
        step();
        alu_we_i = 1'b1;
        alu_rn_i = 5'd5;
        settle_and_check();
        step();
        alu_rn_i = '0;
        mem_rn_i = '0;
        rs_i     = '0;
        settle_and_check();
        u_checker.end_test("priority");
    endtask

    task automatic check_operand_hold();
        step();
        clear_inputs();
        advance_i = 1'b1;
        rs_i      = 5'd2;
        rt_i      = 5'd6;
        settle_and_check();
        for (int i = 0; i < 4; i++) begin
            step();
            advance_i    = 1'b0;
            rs_i         = 5'd1;   // Decode moves on while the ALU stage is held
            rt_i         = 5'd4;
            alu_we_i     = rand_bit();
            alu_rn_i     = (i % 2 == 0) ? 5'd2 : 5'd6;
            alu_result_i = rand_word();
            mem_we_i     = 1'b1;
            mem_rn_i     = (i < 2) ? 5'd6 : 5'd2;
            mem_data_i   = rand_word();
            settle_and_check();
        end
        u_checker.end_test("operand_hold");
    endtask

    task automatic check_random_run();
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            step();
            rs_i         = rand_num();
            rt_i         = rand_num();
            advance_i    = rand_bit();
            alu_we_i     = rand_bit();
            alu_rn_i     = rand_num();
            alu_result_i = rand_word();
            mem_we_i     = rand_bit();
            mem_rn_i     = rand_num();
            mem_data_i   = rand_word();
            wb_we_i      = rand_bit();
            wb_rn_i      = rand_num();
            wb_data_i    = rand_word();
            settle_and_check();
        end
        u_checker.end_test("random_run");
    endtask

    initial begin
        lcg_state = LCG_SEED;
        check_en  = 1'b0;
        reset_i   = 1'b1;
        clear_inputs();
        for (int r = 0; r < NUM_REGS; r++) begin
            shadow_regs[r] = '0;   // Only ever read after the register file test writes them
        end
        shadow_ex_rs_num  = '0;
        shadow_ex_rt_num  = '0;
        shadow_ex_rs_data = '0;
        shadow_ex_rt_data = '0;
        foreach (exp_data[k]) begin
            exp_data[k] = '0;
            exp_sel[k]  = FWD_NONE;
        end

        step();
        step();
        reset_i  = 1'b0;
        check_en = 1'b1;

        check_reset_state();
        check_reg_file();
        check_priority();
        check_operand_hold();
        check_random_run();

        u_checker.print_totals();
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : tb_forward_top
